/* predecodePkg.sv */
package predecodePkg;

    // Byte address or PC
    typedef logic [31:0] addr_t;

    // One instruction halfword
    typedef logic [15:0] half_t;

    // Halfwords per fetch packet
    localparam int DefaultNumInst = 8;

    // Major opcode of jal
    localparam logic [6:0] OpJal = 7'b1101111;

    // Compressed quadrant 1 and its funct3 codes for c.j and c.jal
    localparam logic [1:0] QuadC1 = 2'b01;
    localparam logic [2:0] FunctCj = 3'b101;
    localparam logic [2:0] FunctCjal = 3'b001;

    // A jal that writes either link register is a call
    localparam logic [4:0] LinkRa = 5'd1;
    localparam logic [4:0] LinkT0 = 5'd5;

endpackage

/* fetchAligner.sv */
`timescale 1ns/10ps

module fetchAligner #(
    parameter int numInst = predecodePkg::DefaultNumInst
) (
    input  logic clk,
    input  logic rst,
    input  logic clear,

    input  logic inValid,
    input  logic inReady,
    input  predecodePkg::addr_t inPc,
    input  logic [$clog2(numInst)-1:0] inLastValid,
    input  predecodePkg::half_t [numInst-1:0] inInstrs,

    input  logic taken,

    output logic accept,
    output predecodePkg::half_t [numInst:0] view,
    output logic [numInst:0] is16,
    output logic [numInst:0] is32,
    output predecodePkg::addr_t [numInst:0] pcs,
    output logic [$clog2(numInst)-1:0] firstOffs
);
    import predecodePkg::*;

    localparam int offsW = $clog2(numInst);
    typedef logic [offsW-1:0] offs_t;

    // First half of a 32-bit instruction left over from the previous packet
    half_t carryHalf;
    addr_t carryPc;
    logic carryValid;

    addr_t packetBase;
    logic [offsW:0] lastIdx;
    logic keepCarry;

    assign accept = inValid && inReady;

    // Position 0 holds the carried halfword and the packet follows from position 1
    assign view = {inInstrs, carryHalf};

    assign firstOffs = carryValid ? offs_t'(0) : inPc[1 +: offsW];

    // Walk the halfwords and mark where instructions start
    always_comb begin
        logic startHere;
        offs_t hwOffs;
        is16 = '0;
        is32 = '0;
        startHere = 1'b1;
        if (carryValid) begin
            is32[0] = 1'b1;
            startHere = 1'b0;
        end
        for (int i = 1; i <= numInst; i++) begin
            hwOffs = offs_t'(i - 1);
            if (startHere && hwOffs >= firstOffs && hwOffs <= inLastValid) begin
                if (view[i][1:0] == 2'b11) begin
                    is32[i] = 1'b1;
                    startHere = 1'b0;
                end else begin
                    is16[i] = 1'b1;
                end
            end else begin
                // Second half of a 32-bit instruction or outside the window
                startHere = 1'b1;
            end
        end
    end

    // Halfword PCs relative to the aligned packet base
    assign packetBase = {inPc[31:offsW+1], {(offsW + 1){1'b0}}};

    always_comb begin
        pcs[0] = carryPc;
        for (int i = 1; i <= numInst; i++) begin
            pcs[i] = packetBase + addr_t'((i - 1) * 2);
        end
    end

    // A 32-bit start on the last valid halfword waits for the next packet
    assign lastIdx = {1'b0, inLastValid} + 1'b1;
    assign keepCarry = is32[lastIdx] && !taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            carryValid <= 1'b0;
        end else if (clear) begin
            carryValid <= 1'b0;
        end else if (accept) begin
            carryValid <= keepCarry;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            carryHalf <= view[lastIdx];
            carryPc <= pcs[lastIdx];
        end
    end

endmodule

/* jumpScanner.sv */
`timescale 1ns/10ps

module jumpScanner #(
    parameter int numInst = predecodePkg::DefaultNumInst
) (
    input  predecodePkg::half_t [numInst:0] view,
    input  logic [numInst:0] is16,
    input  logic [numInst:0] is32,
    input  predecodePkg::addr_t [numInst:0] pcs,
    input  logic [$clog2(numInst)-1:0] inLastValid,

    output logic taken,
    output predecodePkg::addr_t dst,
    output logic isCall,
    output logic endValid,
    output logic [$clog2(numInst)-1:0] endOffs
);
    import predecodePkg::*;

    localparam int offsW = $clog2(numInst);
    typedef logic [offsW-1:0] offs_t;

    // Jump kinds found at a start position
    typedef logic [1:0] kind_t;
    localparam kind_t KindNone = 2'd0;
    localparam kind_t KindJump = 2'd1;
    localparam kind_t KindCall = 2'd2;

    kind_t candKind [numInst:0];
    addr_t candDst [numInst:0];
    offs_t candFinal [numInst:0];

    // J-type immediate of jal
    function automatic addr_t jImm(input logic [31:0] word);
        return {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    endfunction

    // CJ immediate shared by c.j and c.jal
    function automatic addr_t cjImm(input half_t hw);
        return {{20{hw[12]}}, hw[12], hw[8], hw[10:9], hw[6], hw[7], hw[2], hw[11],
                hw[5:3], 1'b0};
    endfunction

    // Decode a possible jump at every start position
    always_comb begin
        logic [31:0] word;
        half_t hw;
        for (int p = 0; p <= numInst; p++) begin
            candKind[p] = KindNone;
            candDst[p] = '0;
            candFinal[p] = '0;
        end

        // jal needs both halves inside the packet window
        for (int p = 0; p < numInst; p++) begin
            word = {view[p + 1], view[p]};
            if (is32[p] && word[6:0] == OpJal && offs_t'(p) <= inLastValid) begin
                candKind[p] = (word[11:7] == LinkRa || word[11:7] == LinkT0)
                    ? KindCall : KindJump;
                candDst[p] = pcs[p] + jImm(word);
                candFinal[p] = offs_t'(p);
            end
        end

        // Position 0 never holds a compressed start, so c.j and c.jal begin at 1
        for (int p = 1; p <= numInst; p++) begin
            hw = view[p];
            if (is16[p] && hw[1:0] == QuadC1 &&
                    (hw[15:13] == FunctCj || hw[15:13] == FunctCjal)) begin
                candKind[p] = (hw[15:13] == FunctCjal) ? KindCall : KindJump;
                candDst[p] = pcs[p] + cjImm(hw);
                candFinal[p] = offs_t'(p - 1);
            end
        end
    end

    // The lowest position wins
    always_comb begin
        kind_t kind;
        addr_t target;
        offs_t finalOffs;
        kind = KindNone;
        target = '0;
        finalOffs = '0;
        for (int p = 0; p <= numInst; p++) begin
            if (kind == KindNone && candKind[p] != KindNone) begin
                kind = candKind[p];
                target = candDst[p];
                finalOffs = candFinal[p];
            end
        end

        taken = (kind != KindNone);
        isCall = (kind == KindCall);
        dst = target;

        // Nothing to cut when the jump already ends the packet
        endValid = taken && (finalOffs != '1);
        endOffs = taken ? offs_t'(finalOffs + 1'b1) : '0;
    end

endmodule

/* redirectReg.sv */
`timescale 1ns/10ps

module redirectReg #(
    parameter int numInst = predecodePkg::DefaultNumInst
) (
    input  logic clk,
    input  logic rst,
    input  logic clear,

    input  logic accept,
    input  logic taken,
    input  predecodePkg::addr_t dst,
    input  logic isCall,
    input  logic endValid,
    input  logic [$clog2(numInst)-1:0] endOffs,

    input  logic outReady,
    output logic full,

    output logic outValid,
    output logic outTaken,
    output predecodePkg::addr_t outDst,
    output logic outIsCall,
    output logic outEndValid,
    output logic [$clog2(numInst)-1:0] outEndOffs
);

    logic drain;

    assign drain = outValid && outReady;
    assign full = outValid;

    // A new load wins over a drain in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (clear) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
        end else if (drain) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outTaken <= taken;
            outDst <= dst;
            outIsCall <= isCall;
            outEndValid <= endValid;
            outEndOffs <= endOffs;
        end
    end

endmodule

/* branchPredecode.sv */
`timescale 1ns/10ps

module branchPredecode #(
    parameter int numInst = predecodePkg::DefaultNumInst
) (
    input  logic clk,
    input  logic rst,
    input  logic clear,

    input  logic inValid,
    output logic inReady,
    input  predecodePkg::addr_t inPc,
    input  logic [$clog2(numInst)-1:0] inLastValid,
    input  predecodePkg::half_t [numInst-1:0] inInstrs,

    output logic outValid,
    input  logic outReady,
    output logic outTaken,
    output predecodePkg::addr_t outDst,
    output logic outIsCall,
    output logic outEndValid,
    output logic [$clog2(numInst)-1:0] outEndOffs
);
    import predecodePkg::*;

    localparam int offsW = $clog2(numInst);

    logic accept;
    half_t [numInst:0] view;
    logic [numInst:0] is16;
    logic [numInst:0] is32;
    addr_t [numInst:0] pcs;

    logic taken;
    addr_t dst;
    logic isCall;
    logic endValid;
    logic [offsW-1:0] endOffs;
    logic full;

    // Room for a packet when the register is empty or drains this cycle
    assign inReady = !clear && (!full || outReady);

    fetchAligner #(
        .numInst(numInst)
    ) aligner (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .inValid(inValid),
        .inReady(inReady),
        .inPc(inPc),
        .inLastValid(inLastValid),
        .inInstrs(inInstrs),
        .taken(taken),
        .accept(accept),
        .view(view),
        .is16(is16),
        .is32(is32),
        .pcs(pcs),
        .firstOffs()
    );

    jumpScanner #(
        .numInst(numInst)
    ) scanner (
        .view(view),
        .is16(is16),
        .is32(is32),
        .pcs(pcs),
        .inLastValid(inLastValid),
        .taken(taken),
        .dst(dst),
        .isCall(isCall),
        .endValid(endValid),
        .endOffs(endOffs)
    );

    redirectReg #(
        .numInst(numInst)
    ) result (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .accept(accept),
        .taken(taken),
        .dst(dst),
        .isCall(isCall),
        .endValid(endValid),
        .endOffs(endOffs),
        .outReady(outReady),
        .full(full),
        .outValid(outValid),
        .outTaken(outTaken),
        .outDst(outDst),
        .outIsCall(outIsCall),
        .outEndValid(outEndValid),
        .outEndOffs(outEndOffs)
    );

endmodule

/* branchPredecode_tb.sv */
`timescale 1ns/10ps

module branchPredecode_tb;
    import predecodePkg::*;

    localparam int NumInst = DefaultNumInst;
    localparam int OffsW = $clog2(NumInst);
    localparam int NumTests = 6;
    typedef logic [OffsW-1:0] offs_t;
    localparam offs_t LastOffs = offs_t'(NumInst - 1);

    logic clk;
    logic rst;
    logic clear;
    logic inValid;
    logic inReady;
    addr_t inPc;
    offs_t inLastValid;
    half_t [NumInst-1:0] inInstrs;
    logic outValid;
    logic outReady;
    logic outTaken;
    addr_t outDst;
    logic outIsCall;
    logic outEndValid;
    offs_t outEndOffs;

    // Packet under construction and the last result seen
    half_t [NumInst-1:0] pkt;
    logic gotTaken;
    addr_t gotDst;
    logic gotCall;
    logic gotEndValid;
    offs_t gotEndOffs;

    logic [31:0] rngState;
    int errors;
    string testName;

    branchPredecode #(
        .numInst(NumInst)
    ) DUT (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .inValid(inValid),
        .inReady(inReady),
        .inPc(inPc),
        .inLastValid(inLastValid),
        .inInstrs(inInstrs),
        .outValid(outValid),
        .outReady(outReady),
        .outTaken(outTaken),
        .outDst(outDst),
        .outIsCall(outIsCall),
        .outEndValid(outEndValid),
        .outEndOffs(outEndOffs)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] randWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Random c.addi filler that never decodes as a jump
    function automatic half_t encFill();
        logic [31:0] r;
        r = randWord();
        return {3'b000, r[5], r[10:6], r[4:0], 2'b01};
    endfunction

    // 32-bit addi with random fields
    function automatic logic [31:0] encAddi();
        logic [31:0] r;
        r = randWord();
        return {r[31:20], r[19:15], 3'b000, r[11:7], 7'b0010011};
    endfunction

    function automatic logic [31:0] encJal(input logic [4:0] rd, input int imm);
        logic [20:0] i;
        i = imm[20:0];
        return {i[20], i[10:1], i[11], i[19:12], rd, OpJal};
    endfunction

    // c.j or c.jal depending on funct
    function automatic half_t encCj(input logic [2:0] funct, input int imm);
        logic [11:0] i;
        i = imm[11:0];
        return {funct, i[11], i[4], i[9:8], i[10], i[6], i[7], i[3:1], i[5], QuadC1};
    endfunction

    // PC of a halfword in a packet whose first halfword sits at base
    function automatic addr_t hwPc(input addr_t base, input int offs);
        return base + addr_t'(2 * offs);
    endfunction

    task automatic fillPacket();
        for (int k = 0; k < NumInst; k++) begin
            pkt[k] = encFill();
        end
    endtask

    task automatic placeWord(input int k, input logic [31:0] w);
        pkt[k] = w[15:0];
        pkt[k + 1] = w[31:16];
    endtask

    task automatic checkAddr(input string what, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            errors++;
            $display("error %s %s: expected %h actual %h", testName, what, exp, act);
        end
    endtask

    task automatic checkBit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("error %s %s: expected %b actual %b", testName, what, exp, act);
        end
    endtask

    task automatic checkOffs(input string what, input offs_t exp, input offs_t act);
        if (exp !== act) begin
            errors++;
            $display("error %s %s: expected %0d actual %0d", testName, what, exp, act);
        end
    endtask

    task automatic drivePacket(input addr_t pc, input offs_t lastValid);
        inValid <= 1'b1;
        inPc <= pc;
        inLastValid <= lastValid;
        inInstrs <= pkt;
    endtask

    // Offer the packet until it is taken
    task automatic sendPacket(input addr_t pc, input offs_t lastValid);
        @(posedge clk);
        drivePacket(pc, lastValid);
        @(negedge clk);
        while (!inReady) begin
            @(negedge clk);
        end
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    task automatic captureResult();
        gotTaken = outTaken;
        gotDst = outDst;
        gotCall = outIsCall;
        gotEndValid = outEndValid;
        gotEndOffs = outEndOffs;
    endtask

    task automatic receiveResult();
        @(negedge clk);
        while (!outValid) begin
            @(negedge clk);
        end
        captureResult();
    endtask

    // finalOffs is the offset of the jump's last halfword
    task automatic expectJump(input addr_t expDst, input logic expCall, input int finalOffs);
        checkBit("taken", 1'b1, gotTaken);
        checkAddr("dst", expDst, gotDst);
        checkBit("isCall", expCall, gotCall);
        checkBit("endValid", finalOffs != NumInst - 1, gotEndValid);
        checkOffs("endOffs", offs_t'(finalOffs + 1), gotEndOffs);
    endtask

    task automatic expectNone();
        checkBit("taken", 1'b0, gotTaken);
    endtask

    task automatic testCompressedJump();
        testName = "compressedJump";
        fillPacket();
        pkt[3] = encCj(FunctCj, 'h40);
        sendPacket(32'h1000, LastOffs);
        receiveResult();
        expectJump(hwPc(32'h1000, 3) + addr_t'('h40), 1'b0, 3);
        fillPacket();
        pkt[3] = encCj(FunctCjal, -'h20);
        sendPacket(32'h1000, LastOffs);
        receiveResult();
        expectJump(hwPc(32'h1000, 3) - addr_t'('h20), 1'b1, 3);
    endtask

    task automatic testJal();
        testName = "jal";
        fillPacket();
        placeWord(2, encJal(LinkRa, 'h1234));
        sendPacket(32'h2000, LastOffs);
        receiveResult();
        expectJump(hwPc(32'h2000, 2) + addr_t'('h1234), 1'b1, 3);
        // Plain jump that ends the packet
        fillPacket();
        placeWord(6, encJal(5'd0, -'h800));
        sendPacket(32'h2010, LastOffs);
        receiveResult();
        expectJump(hwPc(32'h2010, 6) - addr_t'('h800), 1'b0, 7);
        fillPacket();
        pkt[1] = encCj(FunctCj, 'h20);
        placeWord(4, encJal(LinkRa, 'h100));
        sendPacket(32'h2100, LastOffs);
        receiveResult();
        expectJump(hwPc(32'h2100, 1) + addr_t'('h20), 1'b0, 1);
    endtask

    task automatic testNoJump();
        testName = "noJump";
        fillPacket();
        placeWord(2, encAddi());
        sendPacket(32'h3000, LastOffs);
        receiveResult();
        expectNone();
        // Jumps before the start offset and past the last valid halfword
        fillPacket();
        pkt[1] = encCj(FunctCj, 'h40);
        pkt[6] = encCj(FunctCjal, 'h40);
        sendPacket(32'h3014, offs_t'(5));
        receiveResult();
        expectNone();
    endtask

    task automatic testSplitJal();
        logic [31:0] w;
        testName = "splitJal";
        w = encJal(LinkT0, -'h100);
        fillPacket();
        pkt[7] = w[15:0];
        sendPacket(32'h4000, LastOffs);
        receiveResult();
        expectNone();
        fillPacket();
        pkt[0] = w[31:16];
        sendPacket(32'h4010, LastOffs);
        receiveResult();
        expectJump(hwPc(32'h4000, 7) - addr_t'('h100), 1'b1, 0);
    endtask

    task automatic testBackPressure();
        addr_t firstDst;
        testName = "backPressure";
        firstDst = hwPc(32'h5000, 0) + addr_t'('h10);
        @(posedge clk);
        outReady <= 1'b0;
        fillPacket();
        pkt[0] = encCj(FunctCj, 'h10);
        sendPacket(32'h5000, LastOffs);
        fillPacket();
        pkt[5] = encCj(FunctCjal, -'h30);
        @(posedge clk);
        drivePacket(32'h5010, LastOffs);
        repeat (5) begin
            @(negedge clk);
            checkBit("outValid held", 1'b1, outValid);
            checkBit("inReady held", 1'b0, inReady);
            captureResult();
            expectJump(firstDst, 1'b0, 0);
        end
        @(posedge clk);
        outReady <= 1'b1;
        @(negedge clk);
        checkBit("inReady on drain", 1'b1, inReady);
        captureResult();
        expectJump(firstDst, 1'b0, 0);
        @(posedge clk);
        inValid <= 1'b0;
        receiveResult();
        expectJump(hwPc(32'h5010, 5) - addr_t'('h30), 1'b1, 5);
    endtask

    task automatic testClearSplit();
        logic [31:0] w;
        testName = "clearSplit";
        w = encJal(5'd0, 'h80);
        fillPacket();
        pkt[7] = w[15:0];
        sendPacket(32'h6000, LastOffs);
        receiveResult();
        expectNone();
        @(posedge clk);
        clear <= 1'b1;
        @(negedge clk);
        checkBit("inReady during clear", 1'b0, inReady);
        @(posedge clk);
        clear <= 1'b0;
        // The upper jal half now starts a compressed instruction
        fillPacket();
        pkt[0] = w[31:16];
        sendPacket(32'h6010, LastOffs);
        receiveResult();
        expectNone();
    endtask

    initial begin
        repeat (NumTests * 200) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        clear = 1'b0;
        inValid = 1'b0;
        inPc = '0;
        inLastValid = '0;
        inInstrs = '0;
        outReady = 1'b1;
        rngState = 32'h43c0;
        errors = 0;
        pkt = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        testCompressedJump();
        testJal();
        testNoJump();
        testSplitJal();
        testBackPressure();
        testClearSplit();
        repeat (3) @(posedge clk);
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* branchPredecode.f */
predecodePkg.sv
fetchAligner.sv
jumpScanner.sv
redirectReg.sv
branchPredecode.sv
branchPredecode_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= branchPredecode_tb
FILELIST ?= branchPredecode.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing
PASS_MSG ?= Simulation completed successfully

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
